// File: Bender.yml
package:
  name: scc_shadow

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/scc_chain_pkg.sv
      - rtl/scc_cmd_pkg.sv
      - rtl/scc_bit_counter.sv
      - rtl/scc_scan_shifter.sv
      - rtl/core_shadow_registers.sv
      - rtl/scc_sequencer.sv
      - rtl/scc_shadow_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_scc_shadow.sv

// File: include/scc_settings.svh
// scan-chain controller build settings tied to the PHY configuration
`ifndef SCC_SETTINGS_SVH
`define SCC_SETTINGS_SVH

// number of bits in one per-rank settings word, which is also the scan chain length
`define SCC_SETTINGS_WIDTH 12

// ranks served by the shadow register block
`define SCC_NUM_RANKS 2

// bits needed to name one rank, must cover SCC_NUM_RANKS
`define SCC_RANK_BITS 1

// upper bound in clock cycles for any single handshake wait in the testbench
// a full shift command finishes well inside this
`define SCC_TIMEOUT_CYCLES 200

`endif

// File: rtl/core_shadow_registers.sv
// per-rank shadow registers holding the settings used by the core, with commit and readback
`timescale 1ns/1ps
`include "scc_settings.svh"

module core_shadow_registers (
	input  logic                      scc_clk,
	input  logic                      scc_reset_n,
	input  logic                      scc_update,
	input  scc_chain_pkg::rank_t      scc_rank,
	input  scc_chain_pkg::settings_t  scc_settings_in,
	input  scc_chain_pkg::rank_t      rank_select,
	input  scc_chain_pkg::rank_t      read_rank,
	output scc_chain_pkg::settings_t  settings_out,
	output scc_chain_pkg::settings_t  read_settings
);

	import scc_chain_pkg::*;

	// one settings word per rank
	settings_t rank_settings [`SCC_NUM_RANKS];

	always_ff @(posedge scc_clk or negedge scc_reset_n)
	begin
		if (!scc_reset_n)
		begin
			for (int r = 0; r < `SCC_NUM_RANKS; r++)
				rank_settings[r] <= '0;
		end
		else if (scc_update)
		begin
			rank_settings[scc_rank] <= scc_settings_in;
		end
	end

	// the core follows rank_select with no register in the path,
	// a commit shows up here on the cycle after the update pulse
	assign settings_out = rank_settings[rank_select];

	// second read port for the sequencer so a readback never disturbs the core view
	assign read_settings = rank_settings[read_rank];

	// a commit must name a rank that exists
	assert property (@(posedge scc_clk) disable iff (!scc_reset_n)
		scc_update |-> (int'(scc_rank) < `SCC_NUM_RANKS))
		else $error("shadow commit to rank %0d out of range", scc_rank);

endmodule

// File: rtl/scc_bit_counter.sv
// down-counter that times the serial shift and flags the cycle of the last bit
`timescale 1ns/1ps
`include "scc_settings.svh"

module scc_bit_counter (
	input  logic scc_clk,
	input  logic scc_reset_n,
	input  logic cnt_load,
	input  logic cnt_en,
	output logic cnt_done
);

	localparam int CNT_W = $clog2(`SCC_SETTINGS_WIDTH);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SCC_SETTINGS_WIDTH - 1);

	logic [CNT_W-1:0] count;
	logic             armed;

	// the step taken at count zero is the last one of the word
	// armed keeps an idle zero count from looking like a finished shift
	assign cnt_done = cnt_en && armed && (count == '0);

	always_ff @(posedge scc_clk or negedge scc_reset_n)
	begin
		if (!scc_reset_n)
		begin
			count <= '0;
			armed <= 1'b0;
		end
		else if (cnt_load)
		begin
			count <= CNT_LAST;
			armed <= 1'b1;
		end
		else if (cnt_en && armed)
		begin
			// hold at zero once the word is done, the next shift reloads
			if (count == '0)
				armed <= 1'b0;
			else
				count <= count - 1'b1;
		end
	end

	// the sequencer must reload before stepping again once a word is complete
	assert property (@(posedge scc_clk) disable iff (!scc_reset_n)
		((count == '0) && !armed && !cnt_load) |-> !cnt_en)
		else $error("bit counter enabled after the shift finished without a reload");

endmodule

// File: rtl/scc_chain_pkg.sv
// types for the settings data and the scan chain control of the scan-chain controller
`include "scc_settings.svh"

package scc_chain_pkg;

	// one settings word as it sits in the chain and in a shadow register
	typedef logic [`SCC_SETTINGS_WIDTH-1:0] settings_t;

	// index of a rank, used both by the host command and by the core
	typedef logic [`SCC_RANK_BITS-1:0] rank_t;

	// control from the sequencer to the scan shifter
	// load copies the source word in and clears the capture register
	// step moves every register of the chain by one bit
	// the sequencer never raises both in the same cycle
	typedef struct packed {
		logic load;
		logic step;
	} scc_shift_ctrl_t;

endpackage

// File: rtl/scc_cmd_pkg.sv
// types for the host command interface and the sequencer of the scan-chain controller
package scc_cmd_pkg;

	import scc_chain_pkg::*;

	// all four codes are legal, so there is no error opcode
	typedef enum logic [1:0] {
		SCC_OP_SHIFT        = 2'd0,
		SCC_OP_COMMIT       = 2'd1,
		SCC_OP_SHIFT_COMMIT = 2'd2,
		SCC_OP_READBACK     = 2'd3
	} scc_op_e;

	// host command, held stable by the host while cmd_req is high and cmd_ack is low
	// rank is ignored by a plain shift, data is ignored by commit and readback
	typedef struct packed {
		scc_op_e   op;
		rank_t     rank;
		settings_t data;
	} scc_cmd_t;

	// sequencer states
	// ST_SHIFT runs the serial move, ST_COMMIT pulses the shadow write,
	// ST_READ gives the readback mux a cycle to settle,
	// ST_ACK raises the acknowledge and waits for the host to drop its request,
	// ST_RELEASE is the one cycle gap before a new command can be taken
	typedef enum logic [2:0] {
		ST_IDLE    = 3'd0,
		ST_SHIFT   = 3'd1,
		ST_COMMIT  = 3'd2,
		ST_READ    = 3'd3,
		ST_ACK     = 3'd4,
		ST_RELEASE = 3'd5
	} scc_state_e;

endpackage

// File: rtl/scc_scan_shifter.sv
// serial scan shifter with source, chain and capture registers moving one bit per step
`timescale 1ns/1ps

module scc_scan_shifter (
	input  logic                            scc_clk,
	input  logic                            scc_reset_n,
	input  scc_chain_pkg::scc_shift_ctrl_t  shift_ctrl,
	input  scc_chain_pkg::settings_t        source,
	output scc_chain_pkg::settings_t        chain,
	output scc_chain_pkg::settings_t        captured
);

	import scc_chain_pkg::*;

	// word still waiting to enter the chain, drained from the LSB end
	settings_t source_q;

	always_ff @(posedge scc_clk or negedge scc_reset_n)
	begin
		if (!scc_reset_n)
		begin
			source_q <= '0;
			chain    <= '0;
			captured <= '0;
		end
		else if (shift_ctrl.load)
		begin
			// the chain itself is left alone, it still holds the previous word
			source_q <= source;
			captured <= '0;
		end
		else if (shift_ctrl.step)
		begin
			// bits enter the chain at the MSB and leave it at the LSB,
			// so after a full word the chain holds the source and captured holds the old chain
			source_q <= source_q >> 1;
			chain    <= {source_q[0], chain[$bits(settings_t)-1:1]};
			captured <= {chain[0], captured[$bits(settings_t)-1:1]};
		end
	end

	// a load in the middle of a step would corrupt both the chain and the capture
	assert property (@(posedge scc_clk) disable iff (!scc_reset_n)
		!(shift_ctrl.load && shift_ctrl.step))
		else $error("scan shifter saw load and step together");

endmodule

// File: rtl/scc_sequencer.sv
// command sequencer that decodes host commands, runs the req/ack handshake and steers the chain
`timescale 1ns/1ps

module scc_sequencer (
	input  logic                            scc_clk,
	input  logic                            scc_reset_n,
	input  scc_cmd_pkg::scc_cmd_t           cmd,
	input  logic                            cmd_req,
	input  logic                            cnt_done,
	input  scc_chain_pkg::settings_t        captured,
	input  scc_chain_pkg::settings_t        chain,
	input  scc_chain_pkg::settings_t        read_settings,
	output logic                            cmd_ack,
	output scc_chain_pkg::settings_t        rsp_data,
	output scc_chain_pkg::scc_shift_ctrl_t  shift_ctrl,
	output logic                            cnt_load,
	output logic                            cnt_en,
	output logic                            scc_update,
	output scc_chain_pkg::rank_t            scc_rank,
	output scc_chain_pkg::rank_t            read_rank
);

	import scc_chain_pkg::*;
	import scc_cmd_pkg::*;

	scc_state_e state;
	scc_state_e state_nxt;
	scc_op_e    op_q;
	rank_t      rank_q;
	logic       start_shift;
	settings_t  rsp_sel;

	// a shifting command loads the shifter and the counter on the very edge that accepts it,
	// so the first step already happens in the first ST_SHIFT cycle
	assign start_shift = (state == ST_IDLE) && cmd_req &&
		((cmd.op == SCC_OP_SHIFT) || (cmd.op == SCC_OP_SHIFT_COMMIT));

	assign shift_ctrl.load = start_shift;
	assign shift_ctrl.step = (state == ST_SHIFT);
	assign cnt_load        = start_shift;
	assign cnt_en          = (state == ST_SHIFT);

	// the shadow write is a single cycle pulse, the chain output is the write data
	assign scc_update = (state == ST_COMMIT);
	assign scc_rank   = rank_q;
	assign read_rank  = rank_q;

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
			begin
				if (cmd_req)
				begin
					case (cmd.op)
						SCC_OP_SHIFT:        state_nxt = ST_SHIFT;
						SCC_OP_SHIFT_COMMIT: state_nxt = ST_SHIFT;
						SCC_OP_COMMIT:       state_nxt = ST_COMMIT;
						default:             state_nxt = ST_READ;
					endcase
				end
			end
			ST_SHIFT:
			begin
				// the counter flags the cycle of the last step
				if (cnt_done)
					state_nxt = (op_q == SCC_OP_SHIFT_COMMIT) ? ST_COMMIT : ST_ACK;
			end
			ST_COMMIT:
				state_nxt = ST_ACK;
			ST_READ:
				state_nxt = ST_ACK;
			ST_ACK:
			begin
				// back-pressure is simply a request that stays high
				if (cmd_ack && !cmd_req)
					state_nxt = ST_RELEASE;
			end
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	// response source per opcode
	// a shift returns what fell out of the chain, a commit returns the word written,
	// a readback returns the shadow word of the registered rank
	always_comb
	begin
		case (op_q)
			SCC_OP_SHIFT:        rsp_sel = captured;
			SCC_OP_SHIFT_COMMIT: rsp_sel = captured;
			SCC_OP_COMMIT:       rsp_sel = chain;
			default:             rsp_sel = read_settings;
		endcase
	end

	always_ff @(posedge scc_clk or negedge scc_reset_n)
	begin
		if (!scc_reset_n)
		begin
			state    <= ST_IDLE;
			op_q     <= SCC_OP_SHIFT;
			rank_q   <= '0;
			cmd_ack  <= 1'b0;
			rsp_data <= '0;
		end
		else
		begin
			state <= state_nxt;
			// opcode and rank are kept for the whole command since cmd may change after ack
			if ((state == ST_IDLE) && cmd_req)
			begin
				op_q   <= cmd.op;
				rank_q <= cmd.rank;
			end
			// first ST_ACK cycle, the last step has settled so the response is taken here
			if ((state == ST_ACK) && !cmd_ack)
			begin
				cmd_ack  <= 1'b1;
				rsp_data <= rsp_sel;
			end
			else if ((state == ST_ACK) && !cmd_req)
			begin
				cmd_ack <= 1'b0;
			end
		end
	end

	// the acknowledge only ever answers a request that was high on the edge before
	assert property (@(posedge scc_clk) disable iff (!scc_reset_n)
		$rose(cmd_ack) |-> $past(cmd_req))
		else $error("cmd_ack rose without cmd_req");

	// a commit writes the shadow register exactly once
	assert property (@(posedge scc_clk) disable iff (!scc_reset_n)
		$rose(scc_update) |=> !scc_update)
		else $error("scc_update held longer than one cycle");

	// the host keeps the command stable until it is acknowledged
	assert property (@(posedge scc_clk) disable iff (!scc_reset_n)
		(cmd_req && !cmd_ack && $past(cmd_req) && !$past(cmd_ack)) |-> $stable(cmd))
		else $error("cmd changed while cmd_req was pending");

endmodule

// File: rtl/scc_shadow_top.sv
// top level of the scan-chain controller joining sequencer, counter, shifter and shadow registers
`timescale 1ns/1ps

module scc_shadow_top (
	input  logic                      scc_clk,
	input  logic                      scc_reset_n,
	input  scc_cmd_pkg::scc_cmd_t     cmd,
	input  logic                      cmd_req,
	input  scc_chain_pkg::rank_t      rank_select,
	output logic                      cmd_ack,
	output scc_chain_pkg::settings_t  rsp_data,
	output scc_chain_pkg::settings_t  settings_out
);

	import scc_chain_pkg::*;

	scc_shift_ctrl_t shift_ctrl;
	logic            cnt_load;
	logic            cnt_en;
	logic            cnt_done;
	logic            scc_update;
	rank_t           scc_rank;
	rank_t           read_rank;
	settings_t       chain;
	settings_t       captured;
	settings_t       read_settings;

	// control and handshake
	scc_sequencer u_sequencer (
		.scc_clk       (scc_clk),
		.scc_reset_n   (scc_reset_n),
		.cmd           (cmd),
		.cmd_req       (cmd_req),
		.cnt_done      (cnt_done),
		.captured      (captured),
		.chain         (chain),
		.read_settings (read_settings),
		.cmd_ack       (cmd_ack),
		.rsp_data      (rsp_data),
		.shift_ctrl    (shift_ctrl),
		.cnt_load      (cnt_load),
		.cnt_en        (cnt_en),
		.scc_update    (scc_update),
		.scc_rank      (scc_rank),
		.read_rank     (read_rank)
	);

	scc_bit_counter u_bit_counter (
		.scc_clk     (scc_clk),
		.scc_reset_n (scc_reset_n),
		.cnt_load    (cnt_load),
		.cnt_en      (cnt_en),
		.cnt_done    (cnt_done)
	);

	// the host data word is the source of every shift
	scc_scan_shifter u_scan_shifter (
		.scc_clk     (scc_clk),
		.scc_reset_n (scc_reset_n),
		.shift_ctrl  (shift_ctrl),
		.source      (cmd.data),
		.chain       (chain),
		.captured    (captured)
	);

	// commits always take the full chain contents
	core_shadow_registers u_shadow_registers (
		.scc_clk         (scc_clk),
		.scc_reset_n     (scc_reset_n),
		.scc_update      (scc_update),
		.scc_rank        (scc_rank),
		.scc_settings_in (chain),
		.rank_select     (rank_select),
		.read_rank       (read_rank),
		.settings_out    (settings_out),
		.read_settings   (read_settings)
	);

endmodule

// File: scc_shadow.f
+incdir+include
rtl/scc_chain_pkg.sv
rtl/scc_cmd_pkg.sv
rtl/scc_bit_counter.sv
rtl/scc_scan_shifter.sv
rtl/core_shadow_registers.sv
rtl/scc_sequencer.sv
rtl/scc_shadow_top.sv
tests/tb_scc_shadow.sv

// File: tests/tb_scc_shadow.sv
// testbench for the scan-chain controller, host handshake driver with a chain and shadow model
`timescale 1ns/1ps
`include "scc_settings.svh"

module tb_scc_shadow;

	import scc_chain_pkg::*;
	import scc_cmd_pkg::*;

	logic      scc_clk;
	logic      scc_reset_n;
	scc_cmd_t  cmd;
	logic      cmd_req;
	rank_t     rank_select;
	logic      cmd_ack;
	settings_t rsp_data;
	settings_t settings_out;

	// reference model of the chain and the shadow words
	settings_t model_chain;
	settings_t model_shadow [`SCC_NUM_RANKS];
	settings_t exp_rsp;
	settings_t exp_core;

	int   seed = 32'hfc38_7b5e;
	int   errors;
	int   timeouts;
	int   commands;
	logic hung;

	scc_shadow_top DUT (
		.scc_clk      (scc_clk),
		.scc_reset_n  (scc_reset_n),
		.cmd          (cmd),
		.cmd_req      (cmd_req),
		.rank_select  (rank_select),
		.cmd_ack      (cmd_ack),
		.rsp_data     (rsp_data),
		.settings_out (settings_out)
	);

	initial
	begin
		scc_clk = 1'b0;
		forever #5 scc_clk = ~scc_clk;
	end

	// the core view the model expects for the rank the core is looking at
	always_comb
		exp_core = model_shadow[rank_select];

	// right after reset the acknowledge is idle and the response register is clear
	assert property (@(posedge scc_clk) $rose(scc_reset_n) |-> (!cmd_ack && rsp_data == '0))
		else
		begin
			errors++;
			$display("error cmd_ack/rsp_data after reset expected 0/%h actual %h/%h",
				settings_t'(0), $sampled(cmd_ack), $sampled(rsp_data));
		end

	// the response is checked on the edge where the acknowledge is first seen high
	assert property (@(posedge scc_clk) disable iff (!scc_reset_n)
		$rose(cmd_ack) |-> (rsp_data == exp_rsp))
		else
		begin
			errors++;
			$display("error rsp_data expected %h actual %h", $sampled(exp_rsp), $sampled(rsp_data));
		end

	// with the bus idle the core must see exactly the model's shadow word
	assert property (@(posedge scc_clk) disable iff (!scc_reset_n)
		(!cmd_req && !cmd_ack) |-> (settings_out == exp_core))
		else
		begin
			errors++;
			$display("error settings_out expected %h actual %h",
				$sampled(exp_core), $sampled(settings_out));
		end

	// an idle request can never be answered
	assert property (@(posedge scc_clk) disable iff (!scc_reset_n)
		(!cmd_req && !cmd_ack) |=> !cmd_ack)
		else
		begin
			errors++;
			$display("error cmd_ack expected 0 actual %h", $sampled(cmd_ack));
		end

	// back-pressure holds the acknowledge as long as the request stays high
	assert property (@(posedge scc_clk) disable iff (!scc_reset_n)
		(cmd_req && cmd_ack) |=> cmd_ack)
		else
		begin
			errors++;
			$display("error cmd_ack expected 1 actual %h", $sampled(cmd_ack));
		end

	// once the request drops the acknowledge follows on the next edge
	assert property (@(posedge scc_clk) disable iff (!scc_reset_n)
		(!cmd_req && cmd_ack) |=> !cmd_ack)
		else
		begin
			errors++;
			$display("error cmd_ack expected 0 actual %h", $sampled(cmd_ack));
		end

	// walks rank_select over every rank so the core view is compared for each one
	task automatic sweep_ranks();
		begin
			for (int r = 0; r < `SCC_NUM_RANKS; r++)
			begin
				@(negedge scc_clk);
				rank_select = rank_t'(r);
				@(negedge scc_clk);
			end
		end
	endtask

	// one four-phase transaction where the model takes the command as the request rises
	task automatic run_command(input scc_op_e op, input rank_t rank, input settings_t data,
		input int hold);
		int waited;
		begin
			if (!hung)
			begin
				@(negedge scc_clk);
				// the model moves on the same falling edge that puts the request on the bus
				case (op)
					SCC_OP_SHIFT:
					begin
						exp_rsp     = model_chain;
						model_chain = data;
					end
					SCC_OP_COMMIT:
					begin
						exp_rsp            = model_chain;
						model_shadow[rank] = model_chain;
					end
					SCC_OP_SHIFT_COMMIT:
					begin
						exp_rsp            = model_chain;
						model_chain        = data;
						model_shadow[rank] = data;
					end
					default:
						exp_rsp = model_shadow[rank];
				endcase
				cmd.op   = op;
				cmd.rank = rank;
				cmd.data = data;
				cmd_req  = 1'b1;
				waited   = 0;
				while (!cmd_ack && waited < `SCC_TIMEOUT_CYCLES)
				begin
					@(negedge scc_clk);
					waited++;
				end
				if (!cmd_ack)
				begin
					hung = 1'b1;
					timeouts++;
					$display("timeout waiting for cmd_ack to rise on a %s command", op.name());
					cmd_req = 1'b0;
				end
				else
				begin
					// extra cycles with the request held model a slow host
					repeat (hold) @(negedge scc_clk);
					cmd_req = 1'b0;
					waited  = 0;
					while (cmd_ack && waited < `SCC_TIMEOUT_CYCLES)
					begin
						@(negedge scc_clk);
						waited++;
					end
					if (cmd_ack)
					begin
						hung = 1'b1;
						timeouts++;
						$display("timeout waiting for cmd_ack to fall after cmd_req dropped");
					end
				end
				commands++;
			end
		end
	endtask

	initial
	begin
		logic [31:0] rnd;
		scc_op_e     op;

		scc_reset_n = 1'b0;
		cmd         = '0;
		cmd_req     = 1'b0;
		rank_select = '0;
		model_chain = '0;
		exp_rsp     = '0;
		errors      = 0;
		timeouts    = 0;
		commands    = 0;
		hung        = 1'b0;
		for (int r = 0; r < `SCC_NUM_RANKS; r++)
			model_shadow[r] = '0;

		repeat (8) @(posedge scc_clk);
		@(negedge scc_clk);
		scc_reset_n = 1'b1;

		// cleared shadow words on every rank and a quiet bus
		sweep_ranks();
		repeat (4) @(negedge scc_clk);

		// consecutive shifts where the first one returns the cleared chain
		for (int i = 0; i < 4; i++)
			run_command(SCC_OP_SHIFT, '0, settings_t'($random(seed)), 0);

		// commit into each rank while the other one stays as it was
		run_command(SCC_OP_COMMIT, rank_t'(0), '0, 0);
		sweep_ranks();
		run_command(SCC_OP_SHIFT, '0, settings_t'($random(seed)), 0);
		run_command(SCC_OP_COMMIT, rank_t'(1), '0, 1);
		sweep_ranks();

		// shift and commit together with random ranks
		for (int i = 0; i < 4; i++)
		begin
			rnd = $random(seed);
			run_command(SCC_OP_SHIFT_COMMIT, rank_t'(rnd[20]), settings_t'(rnd), 0);
			sweep_ranks();
		end

		// readback of every rank while the core view keeps moving between them
		for (int r = 0; r < `SCC_NUM_RANKS; r++)
		begin
			run_command(SCC_OP_READBACK, rank_t'(r), '0, 0);
			sweep_ranks();
		end

		// random mix with a random number of held request cycles
		for (int i = 0; i < 24; i++)
		begin
			rnd = $random(seed);
			op  = scc_op_e'(rnd[1:0]);
			run_command(op, rank_t'(rnd[20]), settings_t'(rnd[15:4]), int'(rnd[26:24]));
			if (rnd[30])
				sweep_ranks();
		end

		repeat (4) @(negedge scc_clk);
		$display("%0d commands, %0d assertion errors, %0d timeouts", commands, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
